// ==== src/aic_pctl_params.svh ====
// ----------------------------------------------------------------------
// AI core partition controller parameters
// Bus widths, register map, synchronizer depth and reset delay
// ----------------------------------------------------------------------
`ifndef AIC_PCTL_PARAMS_SVH
`define AIC_PCTL_PARAMS_SVH

`define AIC_APB_ADDR_W   12
`define AIC_APB_DATA_W   32
`define AIC_RVEC_W       40
`define AIC_N_THROTTLE   3
`define AIC_N_FENCES     2
`define AIC_N_BIST       3
`define AIC_SYNC_STAGES  3
`define AIC_RST_DELAY    8

// Register offsets
`define AIC_CSR_CTRL      'h000
`define AIC_CSR_RVEC_LSB  'h004
`define AIC_CSR_RVEC_MSB  'h008
`define AIC_CSR_STATUS    'h00C
`define AIC_CSR_BIST       'h010

`endif

// ==== src/aic_csr_pkg.sv ====
// ----------------------------------------------------------------------
// Configuration bus types
// APB request/response bundles and the register fields seen by the
// partition sequencer
// ----------------------------------------------------------------------
`include "aic_pctl_params.svh"

package aic_csr_pkg;

  typedef logic [`AIC_APB_ADDR_W-1:0]   apb_addr_t;
  typedef logic [`AIC_APB_DATA_W-1:0]   apb_data_t;
  typedef logic [`AIC_APB_DATA_W/8-1:0] apb_strb_t;

  typedef struct packed {
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_strb_t pstrb;
    logic      pwrite;
    logic      psel;
    logic      penable;
  } apb_req_t;

  typedef struct packed {
    logic      pready;
    apb_data_t prdata;
    logic      pslverr;
  } apb_rsp_t;

  typedef logic [`AIC_RVEC_W-1:0] rvec_t;

  // Field order matches the CTRL register layout
  typedef struct packed {
    logic [`AIC_N_THROTTLE-1:0] throttle_en;
    logic                       part_enable;
  } csr_cfg_t;

endpackage

// ==== src/aic_pctl_pkg.sv ====
// ----------------------------------------------------------------------
// Partition controller types
// Sequencer state, synchronized input bundle and status bits
// ----------------------------------------------------------------------
`include "aic_pctl_params.svh"

package aic_pctl_pkg;

  typedef enum logic [2:0] {
    OFF,
    CLK_ON,
    RST_RELEASE,
    FENCE_OPEN,
    ACTIVE,
    FENCE_CLOSE,
    RST_ASSERT
  } pctl_state_e;

  typedef logic [`AIC_N_FENCES-1:0]   fence_t;
  typedef logic [`AIC_N_THROTTLE-1:0] throttle_t;
  typedef logic [`AIC_N_BIST-1:0]     bist_t;

  typedef struct packed {
    throttle_t throttle;
    bist_t     bist;
    fence_t    idle_ack;
    fence_t    idle_val;
  } sync_status_t;

  // Bit 0 is clken, bit 3 is throttle
  typedef struct packed {
    logic throttle;
    logic fence_open;
    logic rst_n;
    logic clken;
  } pctl_status_t;

endpackage

// ==== src/aic_csr_apb.sv ====
// ----------------------------------------------------------------------
// Partition configuration registers
// Zero wait state APB4 slave with byte strobes and error response
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "aic_pctl_params.svh"

module aic_csr_apb (
  input  wire                        i_ref_clk,
  input  wire                        i_arst_n,
  input  aic_csr_pkg::apb_req_t      i_apb_req,
  input  aic_pctl_pkg::pctl_status_t i_status,
  input  aic_pctl_pkg::bist_t        i_bist,
  output aic_csr_pkg::apb_rsp_t      o_apb_rsp,
  output aic_csr_pkg::csr_cfg_t      o_cfg,
  output aic_csr_pkg::rvec_t         o_reset_vector
);

  localparam int unsigned CFG_W = $bits(aic_csr_pkg::csr_cfg_t);
  localparam int unsigned MSB_W = `AIC_RVEC_W - `AIC_APB_DATA_W;

  aic_csr_pkg::csr_cfg_t  ctrl_q;
  aic_csr_pkg::apb_data_t rvec_lsb_q;
  logic [MSB_W-1:0]       rvec_msb_q;

  logic access;
  logic hit_ctrl;
  logic hit_lsb;
  logic hit_msb;
  logic hit_status;
  logic hit_bist;
  logic hit_rw;
  logic hit_ro;
  logic wr_en;
  logic slv_err;

  aic_csr_pkg::apb_data_t ctrl_wdata;
  aic_csr_pkg::apb_data_t lsb_wdata;
  aic_csr_pkg::apb_data_t msb_wdata;
  aic_csr_pkg::apb_data_t rdata;

  // Byte lanes with strobe set take the new data
  function automatic aic_csr_pkg::apb_data_t strb_merge(
    input aic_csr_pkg::apb_data_t old_val,
    input aic_csr_pkg::apb_data_t new_val,
    input aic_csr_pkg::apb_strb_t strb
  );
    aic_csr_pkg::apb_data_t merged;
    merged = old_val;
    for (int b = 0; b < `AIC_APB_DATA_W / 8; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // --------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------
  assign access     = i_apb_req.psel & i_apb_req.penable;
  assign hit_ctrl   = (i_apb_req.paddr == `AIC_CSR_CTRL);
  assign hit_lsb    = (i_apb_req.paddr == `AIC_CSR_RVEC_LSB);
  assign hit_msb    = (i_apb_req.paddr == `AIC_CSR_RVEC_MSB);
  assign hit_status = (i_apb_req.paddr == `AIC_CSR_STATUS);
  assign hit_bist   = (i_apb_req.paddr == `AIC_CSR_BIST);
  assign hit_rw     = hit_ctrl | hit_lsb | hit_msb;
  assign hit_ro     = hit_status | hit_bist;

  assign wr_en   = access & i_apb_req.pwrite & hit_rw;
  // Unmapped offset, or write to a read-only register
  assign slv_err = access & (~(hit_rw | hit_ro) | (i_apb_req.pwrite & hit_ro));

  assign ctrl_wdata = strb_merge(aic_csr_pkg::apb_data_t'(ctrl_q), i_apb_req.pwdata,
                                 i_apb_req.pstrb);
  assign lsb_wdata  = strb_merge(rvec_lsb_q, i_apb_req.pwdata, i_apb_req.pstrb);
  assign msb_wdata  = strb_merge(aic_csr_pkg::apb_data_t'(rvec_msb_q), i_apb_req.pwdata,
                                 i_apb_req.pstrb);

  // --------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------
  always_ff @(posedge i_ref_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ctrl_q     <= '0;
      rvec_lsb_q <= '0;
      rvec_msb_q <= '0;
    end else if (wr_en) begin
      if (hit_ctrl) begin
        ctrl_q <= aic_csr_pkg::csr_cfg_t'(ctrl_wdata[CFG_W-1:0]);
      end
      if (hit_lsb) begin
        rvec_lsb_q <= lsb_wdata;
      end
      if (hit_msb) begin
        rvec_msb_q <= msb_wdata[MSB_W-1:0];
      end
    end
  end

  // Register readback including the live status and BIST bits
  always_comb begin
    rdata = '0;
    if (access && !i_apb_req.pwrite) begin
      case (i_apb_req.paddr)
        `AIC_CSR_CTRL:     rdata = aic_csr_pkg::apb_data_t'(ctrl_q);
        `AIC_CSR_RVEC_LSB: rdata = rvec_lsb_q;
        `AIC_CSR_RVEC_MSB: rdata = aic_csr_pkg::apb_data_t'(rvec_msb_q);
        `AIC_CSR_STATUS:   rdata = aic_csr_pkg::apb_data_t'(i_status);
        `AIC_CSR_BIST:     rdata = aic_csr_pkg::apb_data_t'(i_bist);
        default:           rdata = '0;
      endcase
    end
  end

  assign o_apb_rsp      = '{pready: 1'b1, prdata: rdata, pslverr: slv_err};
  assign o_cfg          = ctrl_q;
  assign o_reset_vector = {rvec_msb_q, rvec_lsb_q};

endmodule

// ==== src/aic_sync_bank.sv ====
// ----------------------------------------------------------------------
// Synchronizer bank
// One flip-flop chain per asynchronous input bit
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "aic_pctl_params.svh"

module aic_sync_bank #(
  parameter int unsigned WIDTH  = `AIC_N_THROTTLE + `AIC_N_BIST + 2 * `AIC_N_FENCES,
  parameter int unsigned STAGES = `AIC_SYNC_STAGES
) (
  input  wire              i_ref_clk,
  input  wire              i_arst_n,
  input  logic [WIDTH-1:0] i_d,
  output logic [WIDTH-1:0] o_q
);

  // Stage 0 samples the raw inputs
  logic [STAGES-1:0][WIDTH-1:0] stage_q;

  always_ff @(posedge i_ref_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= i_d;
      for (int s = 1; s < STAGES; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

  assign o_q = stage_q[STAGES-1];

endmodule

// ==== src/aic_pctl_ctrl.sv ====
// ----------------------------------------------------------------------
// Partition power sequencer
// Clock enable, reset release and NoC fence handshake on power-up,
// the reverse on power-down, plus the throttle combiner
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "aic_pctl_params.svh"

module aic_pctl_ctrl (
  input  wire                        i_ref_clk,
  input  wire                        i_arst_n,
  input  aic_csr_pkg::csr_cfg_t      i_cfg,
  input  aic_pctl_pkg::sync_status_t i_sync,
  output aic_pctl_pkg::fence_t       o_idle_req,
  output logic                       o_partition_clken,
  output logic                       o_partition_rst_n,
  output logic                       o_throttle,
  output aic_pctl_pkg::pctl_status_t o_status
);

  localparam int unsigned CNT_W = $clog2(`AIC_RST_DELAY + 1);

  aic_pctl_pkg::pctl_state_e state_q;
  logic [CNT_W-1:0]          cnt_q;
  logic                      clken_q;
  logic                      rst_n_q;
  logic                      fence_open_q;
  aic_pctl_pkg::fence_t      idle_req_q;
  logic                      throttle_q;

  logic acks_low;
  logic fences_closed;

  assign acks_low      = ~|i_sync.idle_ack;
  assign fences_closed = (&i_sync.idle_ack) & (&i_sync.idle_val);

  // --------------------------------------------------------------------
  // Sequencer
  // --------------------------------------------------------------------
  always_ff @(posedge i_ref_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q      <= aic_pctl_pkg::OFF;
      cnt_q        <= '0;
      clken_q      <= 1'b0;
      rst_n_q      <= 1'b0;
      fence_open_q <= 1'b0;
      // Fences start isolated
      idle_req_q   <= '1;
    end else begin
      case (state_q)
        aic_pctl_pkg::OFF: begin
          if (i_cfg.part_enable) begin
            clken_q <= 1'b1;
            cnt_q   <= '0;
            state_q <= aic_pctl_pkg::CLK_ON;
          end
        end
        // Let the clock run for the reset delay before release
        aic_pctl_pkg::CLK_ON: begin
          if (cnt_q == CNT_W'(`AIC_RST_DELAY - 1)) begin
            rst_n_q <= 1'b1;
            state_q <= aic_pctl_pkg::RST_RELEASE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        aic_pctl_pkg::RST_RELEASE: begin
          idle_req_q <= '0;
          state_q    <= aic_pctl_pkg::FENCE_OPEN;
        end
        // NoC drops ack once the fence is open again
        aic_pctl_pkg::FENCE_OPEN: begin
          if (acks_low) begin
            fence_open_q <= 1'b1;
            state_q      <= aic_pctl_pkg::ACTIVE;
          end
        end
        aic_pctl_pkg::ACTIVE: begin
          if (!i_cfg.part_enable) begin
            idle_req_q   <= '1;
            fence_open_q <= 1'b0;
            state_q      <= aic_pctl_pkg::FENCE_CLOSE;
          end
        end
        // Hold reset off until every fence reports isolated
        aic_pctl_pkg::FENCE_CLOSE: begin
          if (fences_closed) begin
            rst_n_q <= 1'b0;
            state_q <= aic_pctl_pkg::RST_ASSERT;
          end
        end
        aic_pctl_pkg::RST_ASSERT: begin
          clken_q <= 1'b0;
          state_q <= aic_pctl_pkg::OFF;
        end
        default: begin
          state_q <= aic_pctl_pkg::OFF;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------
  // Throttle combiner
  // --------------------------------------------------------------------
  always_ff @(posedge i_ref_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      throttle_q <= 1'b0;
    end else begin
      throttle_q <= |(i_sync.throttle & i_cfg.throttle_en);
    end
  end

  assign o_idle_req        = idle_req_q;
  assign o_partition_clken = clken_q;
  assign o_partition_rst_n = rst_n_q;
  assign o_throttle        = throttle_q;
  assign o_status          = '{throttle:   throttle_q,
                               fence_open: fence_open_q,
                               rst_n:      rst_n_q,
                               clken:      clken_q};

endmodule

// ==== src/aic_pctl_top.sv ====
// ----------------------------------------------------------------------
// AI core partition controller
// APB configuration, input synchronizers and power sequencer
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "aic_pctl_params.svh"

module aic_pctl_top (
  input  wire                    i_ref_clk,
  input  wire                    i_arst_n,
  // APB
  input  aic_csr_pkg::apb_addr_t i_cfg_apb4_s_paddr,
  input  aic_csr_pkg::apb_data_t i_cfg_apb4_s_pwdata,
  input  aic_csr_pkg::apb_strb_t i_cfg_apb4_s_pstrb,
  input  logic                   i_cfg_apb4_s_pwrite,
  input  logic                   i_cfg_apb4_s_psel,
  input  logic                   i_cfg_apb4_s_penable,
  output logic                   o_cfg_apb4_s_pready,
  output aic_csr_pkg::apb_data_t o_cfg_apb4_s_prdata,
  output logic                   o_cfg_apb4_s_pslverr,
  // Asynchronous status inputs
  input  logic                   i_thermal_throttle_async,
  input  logic                   i_clock_throttle_async,
  input  logic                   i_mvm_throttle_async,
  input  logic                   i_imc_bist_busy_async,
  input  logic                   i_imc_bist_done_async,
  input  logic                   i_imc_bist_pass_async,
  // NoC fences
  output logic                   o_noc_async_idle_req,
  input  logic                   i_noc_async_idle_ack,
  input  logic                   i_noc_async_idle_val,
  output logic                   o_noc_ocpl_tok_async_idle_req,
  input  logic                   i_noc_ocpl_tok_async_idle_ack,
  input  logic                   i_noc_ocpl_tok_async_idle_val,
  // Partition control
  output logic                   o_partition_clken,
  output logic                   o_partition_rst_n,
  output logic                   o_throttle,
  output aic_csr_pkg::rvec_t     o_reset_vector
);

  aic_csr_pkg::apb_req_t      apb_req;
  aic_csr_pkg::apb_rsp_t      apb_rsp;
  aic_csr_pkg::csr_cfg_t      cfg;
  aic_pctl_pkg::pctl_status_t status;
  aic_pctl_pkg::sync_status_t sync_in;
  aic_pctl_pkg::sync_status_t sync_out;
  aic_pctl_pkg::fence_t       idle_req;

  assign apb_req = '{paddr:   i_cfg_apb4_s_paddr,
                     pwdata:  i_cfg_apb4_s_pwdata,
                     pstrb:   i_cfg_apb4_s_pstrb,
                     pwrite:  i_cfg_apb4_s_pwrite,
                     psel:    i_cfg_apb4_s_psel,
                     penable: i_cfg_apb4_s_penable};

  assign o_cfg_apb4_s_pready  = apb_rsp.pready;
  assign o_cfg_apb4_s_prdata  = apb_rsp.prdata;
  assign o_cfg_apb4_s_pslverr = apb_rsp.pslverr;

  // Fence 0 is the main NoC, fence 1 the token NoC
  assign sync_in = '{
    throttle: {i_mvm_throttle_async, i_clock_throttle_async, i_thermal_throttle_async},
    bist:     {i_imc_bist_pass_async, i_imc_bist_done_async, i_imc_bist_busy_async},
    idle_ack: {i_noc_ocpl_tok_async_idle_ack, i_noc_async_idle_ack},
    idle_val: {i_noc_ocpl_tok_async_idle_val, i_noc_async_idle_val}
  };

  assign o_noc_async_idle_req          = idle_req[0];
  assign o_noc_ocpl_tok_async_idle_req = idle_req[1];

  aic_csr_apb u_csr (
    .i_ref_clk     (i_ref_clk),
    .i_arst_n      (i_arst_n),
    .i_apb_req     (apb_req),
    .i_status      (status),
    .i_bist        (sync_out.bist),
    .o_apb_rsp     (apb_rsp),
    .o_cfg         (cfg),
    .o_reset_vector(o_reset_vector)
  );

  aic_sync_bank #(
    .WIDTH ($bits(aic_pctl_pkg::sync_status_t)),
    .STAGES(`AIC_SYNC_STAGES)
  ) u_sync (
    .i_ref_clk(i_ref_clk),
    .i_arst_n (i_arst_n),
    .i_d      (sync_in),
    .o_q      (sync_out)
  );

  aic_pctl_ctrl u_ctrl (
    .i_ref_clk        (i_ref_clk),
    .i_arst_n         (i_arst_n),
    .i_cfg            (cfg),
    .i_sync           (sync_out),
    .o_idle_req       (idle_req),
    .o_partition_clken(o_partition_clken),
    .o_partition_rst_n(o_partition_rst_n),
    .o_throttle       (o_throttle),
    .o_status         (status)
  );

endmodule

// ==== testbench/tb_aic_pctl.sv ====
// ----------------------------------------------------------------------
// Partition controller testbench
// APB driver, NoC fence responder, register model and checks
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "aic_pctl_params.svh"

module tb_aic_pctl;

  localparam int TMO_SHORT = 20;
  localparam int TMO_FENCE = 80;
  localparam int P_CLKEN   = 0;
  localparam int P_RST_N   = 1;
  localparam int P_REQ_ALL = 2;
  localparam int P_ACK_ANY = 3;
  localparam int P_THR_OK  = 4;

  typedef struct packed {
    logic        is_read;
    logic [11:0] addr;
    logic [31:0] got_data;
    logic        got_err;
    logic        got_rdy;
    logic [31:0] exp_data;
    logic        exp_err;
  } xfer_rec_t;

  logic        ref_clk;
  logic        arst_n;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic        pwrite;
  logic        psel;
  logic        penable;
  logic        pready;
  logic [31:0] prdata;
  logic        pslverr;
  logic [2:0]  thr_in;
  logic [2:0]  bist_in;
  logic [1:0]  idle_req;
  logic [1:0]  noc_ack;
  logic [1:0]  noc_val;
  logic        clken;
  logic        rst_n;
  logic        throttle;
  logic [39:0] rvec;

  // Shadow registers and expected live bits
  logic [3:0]  ctrl_m;
  logic [31:0] lsb_m;
  logic [7:0]  msb_m;
  logic [2:0]  exp_pwr;
  logic        exp_throttle;
  logic [2:0]  exp_bist;

  xfer_rec_t   rec_q[$];
  xfer_rec_t   cmp_rec;
  logic [15:0] stim_lfsr;
  logic [15:0] resp_lfsr;
  logic [31:0] rnd;
  logic [31:0] wdata;
  logic [31:0] strb_v;
  logic [11:0] addr;
  logic [1:0]  seen_req;
  logic [31:0] resp_dly;
  int          resp_cnt[2];
  int          closed_cycles;
  int          n;
  int          checks;
  int          errors;
  int          timeouts;

  aic_pctl_top uut (
    .i_ref_clk                    (ref_clk),
    .i_arst_n                     (arst_n),
    .i_cfg_apb4_s_paddr           (paddr),
    .i_cfg_apb4_s_pwdata          (pwdata),
    .i_cfg_apb4_s_pstrb           (pstrb),
    .i_cfg_apb4_s_pwrite          (pwrite),
    .i_cfg_apb4_s_psel            (psel),
    .i_cfg_apb4_s_penable         (penable),
    .o_cfg_apb4_s_pready          (pready),
    .o_cfg_apb4_s_prdata          (prdata),
    .o_cfg_apb4_s_pslverr         (pslverr),
    .i_thermal_throttle_async     (thr_in[0]),
    .i_clock_throttle_async       (thr_in[1]),
    .i_mvm_throttle_async         (thr_in[2]),
    .i_imc_bist_busy_async        (bist_in[0]),
    .i_imc_bist_done_async        (bist_in[1]),
    .i_imc_bist_pass_async        (bist_in[2]),
    .o_noc_async_idle_req         (idle_req[0]),
    .i_noc_async_idle_ack         (noc_ack[0]),
    .i_noc_async_idle_val         (noc_val[0]),
    .o_noc_ocpl_tok_async_idle_req(idle_req[1]),
    .i_noc_ocpl_tok_async_idle_ack(noc_ack[1]),
    .i_noc_ocpl_tok_async_idle_val(noc_val[1]),
    .o_partition_clken            (clken),
    .o_partition_rst_n            (rst_n),
    .o_throttle                   (throttle),
    .o_reset_vector               (rvec)
  );

  initial begin
    ref_clk = 1'b0;
    forever #2 ref_clk = ~ref_clk;
  end

  // --------------------------------------------------------------------
  // Random source and reference model
  // --------------------------------------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int nbits, inout logic [15:0] st, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      st  = lfsr_next(st);
      val = {val[30:0], st[0]};
    end
  endtask

  function automatic logic [31:0] ref_rdata(input logic [11:0] a);
    case (a)
      `AIC_CSR_CTRL:     return {28'h0, ctrl_m};
      `AIC_CSR_RVEC_LSB: return lsb_m;
      `AIC_CSR_RVEC_MSB: return {24'h0, msb_m};
      `AIC_CSR_STATUS:   return {28'h0, exp_throttle, exp_pwr};
      `AIC_CSR_BIST:     return {29'h0, exp_bist};
      default:           return 32'h0;
    endcase
  endfunction

  function automatic logic ref_err(input logic [11:0] a, input logic wr);
    logic ro;
    logic rw;
    ro = (a == `AIC_CSR_STATUS) || (a == `AIC_CSR_BIST);
    rw = (a == `AIC_CSR_CTRL) || (a == `AIC_CSR_RVEC_LSB) || (a == `AIC_CSR_RVEC_MSB);
    return !(ro || rw) || (wr && ro);
  endfunction

  task automatic model_write(input logic [11:0] a, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] cur;
    cur = ref_rdata(a);
    for (int b = 0; b < 4; b++) begin
      if (s[b]) begin
        cur[8*b +: 8] = d[8*b +: 8];
      end
    end
    case (a)
      `AIC_CSR_CTRL:     ctrl_m = cur[3:0];
      `AIC_CSR_RVEC_LSB: lsb_m  = cur;
      `AIC_CSR_RVEC_MSB: msb_m  = cur[7:0];
      default:           ;
    endcase
  endtask

  // --------------------------------------------------------------------
  // APB driver
  // --------------------------------------------------------------------
  task automatic apb_xfer(input logic [11:0] a, input logic wr, input logic [31:0] d,
                          input logic [3:0] s, output logic [31:0] rd, output logic err,
                          output logic rdy);
    @(posedge ref_clk);
    #1;
    paddr   = a;
    pwrite  = wr;
    pwdata  = d;
    pstrb   = s;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge ref_clk);
    #1;
    penable = 1'b1;
    #2;
    rd  = prdata;
    err = pslverr;
    rdy = pready;
    @(posedge ref_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] a, input logic [31:0] d, input logic [3:0] s);
    xfer_rec_t rec;
    apb_xfer(a, 1'b1, d, s, rec.got_data, rec.got_err, rec.got_rdy);
    rec.is_read  = 1'b0;
    rec.addr     = a;
    rec.exp_data = '0;
    rec.exp_err  = ref_err(a, 1'b1);
    if (!rec.exp_err) begin
      model_write(a, d, s);
    end
    rec_q.push_back(rec);
  endtask

  task automatic apb_read(input logic [11:0] a);
    xfer_rec_t rec;
    apb_xfer(a, 1'b0, 32'h0, 4'h0, rec.got_data, rec.got_err, rec.got_rdy);
    rec.is_read  = 1'b1;
    rec.addr     = a;
    rec.exp_data = ref_rdata(a);
    rec.exp_err  = ref_err(a, 1'b0);
    rec_q.push_back(rec);
  endtask

  // --------------------------------------------------------------------
  // Compare process
  // --------------------------------------------------------------------
  always @(posedge ref_clk) begin
    while (rec_q.size() > 0) begin
      cmp_rec = rec_q.pop_front();
      checks++;
      assert (cmp_rec.got_rdy === 1'b1) else begin
        errors++;
        $display("ERROR pready @%h: got %h expected 1", cmp_rec.addr, cmp_rec.got_rdy);
      end
      assert (cmp_rec.got_err === cmp_rec.exp_err) else begin
        errors++;
        $display("ERROR pslverr @%h: got %h expected %h", cmp_rec.addr, cmp_rec.got_err,
                 cmp_rec.exp_err);
      end
      if (cmp_rec.is_read) begin
        assert (cmp_rec.got_data === cmp_rec.exp_data) else begin
          errors++;
          $display("ERROR prdata @%h: got %h expected %h", cmp_rec.addr, cmp_rec.got_data,
                   cmp_rec.exp_data);
        end
      end
    end
  end

  // NoC responder follows each request change after a few random cycles
  initial begin
    seen_req      = 2'b11;
    resp_cnt[0]   = 0;
    resp_cnt[1]   = 0;
    closed_cycles = 0;
    forever begin
      @(posedge ref_clk);
      #1;
      for (int f = 0; f < `AIC_N_FENCES; f++) begin
        if (idle_req[f] !== seen_req[f]) begin
          seen_req[f] = idle_req[f];
          rand_bits(3, resp_lfsr, resp_dly);
          resp_cnt[f] = resp_dly + 3;
        end else if (resp_cnt[f] > 0) begin
          resp_cnt[f]--;
          // Ack leads val by two cycles
          if (resp_cnt[f] == 2) begin
            noc_ack[f] = seen_req[f];
          end
          if (resp_cnt[f] == 0) begin
            noc_val[f] = seen_req[f];
          end
        end
      end
      if (&noc_ack && &noc_val) begin
        closed_cycles++;
      end else begin
        closed_cycles = 0;
      end
    end
  end

  function automatic logic probe(input int sel);
    case (sel)
      P_CLKEN:   return clken;
      P_RST_N:   return rst_n;
      P_REQ_ALL: return &idle_req;
      P_ACK_ANY: return |noc_ack;
      P_THR_OK:  return throttle === exp_throttle;
      default:   return 1'b0;
    endcase
  endfunction

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  task automatic wait_for(input int sel, input logic level, input int tmo, input string what,
                          output int cycles);
    cycles = 0;
    while (probe(sel) !== level) begin
      if (cycles >= tmo) begin
        $display("Timeout while waiting for %s", what);
        timeouts++;
        finish_run();
      end
      @(posedge ref_clk);
      #1;
      cycles++;
    end
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic read_all();
    apb_read(`AIC_CSR_CTRL);
    apb_read(`AIC_CSR_RVEC_LSB);
    apb_read(`AIC_CSR_RVEC_MSB);
    apb_read(`AIC_CSR_STATUS);
    apb_read(`AIC_CSR_BIST);
  endtask

  // --------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------
  initial begin
    arst_n    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pstrb     = '0;
    pwrite    = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    thr_in    = '0;
    bist_in   = '0;
    noc_ack   = 2'b11;
    noc_val   = 2'b11;
    stim_lfsr = 16'd48840;
    resp_lfsr = 16'd48840;
    ctrl_m    = '0;
    lsb_m     = '0;
    msb_m     = '0;
    exp_pwr   = '0;
    exp_throttle = 1'b0;
    exp_bist  = '0;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    repeat (10) @(posedge ref_clk);
    #1;
    arst_n = 1'b1;

    // Reset values
    check_val("o_partition_clken", clken, 0);
    check_val("o_partition_rst_n", rst_n, 0);
    check_val("idle_req", idle_req, 2'b11);
    check_val("o_throttle", throttle, 0);
    read_all();

    // Random register traffic
    for (int i = 0; i < 16; i++) begin
      rand_bits(2, stim_lfsr, rnd);
      addr = 12'((rnd % 3) * 4);
      rand_bits(32, stim_lfsr, wdata);
      rand_bits(4, stim_lfsr, strb_v);
      // Partition stays off here
      if (addr == `AIC_CSR_CTRL) begin
        wdata[0] = 1'b0;
      end
      apb_write(addr, wdata, strb_v[3:0]);
      check_val("o_reset_vector", rvec, {msb_m, lsb_m});
      apb_read(`AIC_CSR_CTRL);
      apb_read(`AIC_CSR_RVEC_LSB);
      apb_read(`AIC_CSR_RVEC_MSB);
    end
    apb_write(12'h014, 32'hFFFF_FFFF, 4'hF);
    apb_write(`AIC_CSR_STATUS, 32'hFFFF_FFFF, 4'hF);
    apb_write(`AIC_CSR_BIST, 32'hFFFF_FFFF, 4'hF);
    apb_read(12'h100);
    read_all();
    check_val("o_reset_vector", rvec, {msb_m, lsb_m});

    // BIST levels through the synchronizers
    for (int i = 0; i < 6; i++) begin
      rand_bits(3, stim_lfsr, rnd);
      bist_in  = rnd[2:0];
      exp_bist = rnd[2:0];
      repeat (`AIC_SYNC_STAGES + 1) @(posedge ref_clk);
      apb_read(`AIC_CSR_BIST);
    end

    // Power-up
    apb_write(`AIC_CSR_CTRL, {28'h0, ctrl_m[3:1], 1'b1}, 4'h1);
    wait_for(P_CLKEN, 1'b1, TMO_SHORT, "clken to rise", n);
    check_val("o_partition_rst_n", rst_n, 0);
    check_val("idle_req", idle_req, 2'b11);
    wait_for(P_RST_N, 1'b1, `AIC_RST_DELAY + 4, "rst_n to rise", n);
    check_val("clken to rst_n cycles", n, `AIC_RST_DELAY);
    check_val("idle_req", idle_req, 2'b11);
    wait_for(P_REQ_ALL, 1'b0, 4, "idle requests to fall", n);
    check_val("idle_req", idle_req, 2'b00);
    wait_for(P_ACK_ANY, 1'b0, TMO_FENCE, "fence acks to drop", n);
    repeat (`AIC_SYNC_STAGES + 2) @(posedge ref_clk);
    exp_pwr = 3'b111;
    apb_read(`AIC_CSR_STATUS);

    // Throttle sources and masks
    for (int i = 0; i < 10; i++) begin
      rand_bits(3, stim_lfsr, rnd);
      apb_write(`AIC_CSR_CTRL, {28'h0, rnd[2:0], 1'b1}, 4'h1);
      rand_bits(3, stim_lfsr, rnd);
      thr_in       = rnd[2:0];
      exp_throttle = |(thr_in & ctrl_m[3:1]);
      wait_for(P_THR_OK, 1'b1, `AIC_SYNC_STAGES + 4, "o_throttle to settle", n);
      repeat (`AIC_SYNC_STAGES + 2) @(posedge ref_clk);
      #1;
      check_val("o_throttle", throttle, exp_throttle);
      apb_read(`AIC_CSR_STATUS);
    end

    // Power-down
    apb_write(`AIC_CSR_CTRL, {28'h0, ctrl_m[3:1], 1'b0}, 4'h1);
    wait_for(P_REQ_ALL, 1'b1, 4, "idle requests to rise", n);
    check_val("o_partition_rst_n", rst_n, 1);
    check_val("o_partition_clken", clken, 1);
    wait_for(P_RST_N, 1'b0, TMO_FENCE, "rst_n to fall", n);
    checks++;
    assert (closed_cycles >= `AIC_SYNC_STAGES + 1) else begin
      errors++;
      $display("Reset was asserted before the NoC reported both fences closed");
    end
    check_val("o_partition_clken", clken, 1);
    wait_for(P_CLKEN, 1'b0, 4, "clken to fall", n);
    check_val("rst_n to clken cycles", n, 1);
    exp_pwr = 3'b000;
    apb_read(`AIC_CSR_STATUS);

    n = 0;
    while (rec_q.size() > 0) begin
      if (n >= TMO_SHORT) begin
        $display("Timeout while draining the compare queue");
        timeouts++;
        finish_run();
      end
      @(posedge ref_clk);
      #1;
      n++;
    end
    finish_run();
  end

endmodule

// ==== files.f ====
+incdir+src
src/aic_csr_pkg.sv
src/aic_pctl_pkg.sv
src/aic_csr_apb.sv
src/aic_sync_bank.sv
src/aic_pctl_ctrl.sv
src/aic_pctl_top.sv
testbench/tb_aic_pctl.sv
